//--- logic/friscv_defines.svh
// friscv execution subsystem
// global size macros

`ifndef FRISCV_DEFINES_SVH
`define FRISCV_DEFINES_SVH

// data path width
`define FRISCV_XLEN 32

// 1 selects the embedded profile with 16 registers
`define FRISCV_RV32E 0

// register count follows the profile
`define FRISCV_REGNUM ((`FRISCV_RV32E) ? 16 : 32)

// data memory size in words, power of two
`define FRISCV_DMEM_DEPTH 64

`endif

//--- logic/friscv_isa_pkg.sv
// rv32i instruction encodings

`default_nettype none

package friscv_isa_pkg;

    // major opcodes
    localparam logic [6:0] OPC_OP    = 7'b0110011;
    localparam logic [6:0] OPC_OPIMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI   = 7'b0110111;
    localparam logic [6:0] OPC_LOAD  = 7'b0000011;
    localparam logic [6:0] OPC_STORE = 7'b0100011;

    // funct3 of the arithmetic and logic group
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    // word size for loads and stores
    localparam logic [2:0] F3_WORD    = 3'b010;

    // funct7, the alternate form selects SUB and SRA
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_LUI
    } alu_op_t;

    ////////////////////////////////////////////////////////////////////
    // instruction layouts, msb first
    ////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_type_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_type_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_type_t;

    // one word, four views
    typedef union packed {
        r_type_t r;
        i_type_t i;
        s_type_t s;
        u_type_t u;
    } instr_t;

endpackage

`default_nettype wire

//--- logic/friscv_core_pkg.sv
// commands and register traffic between blocks

`default_nettype none

`include "friscv_defines.svh"

package friscv_core_pkg;

    import friscv_isa_pkg::*;

    // decoded work for the ALU
    typedef struct packed {
        logic                    valid;
        alu_op_t                 op;
        logic [4:0]              rd;
        logic [4:0]              rs1;
        logic [4:0]              rs2;
        logic                    use_imm;
        logic [`FRISCV_XLEN-1:0] imm;
    } alu_cmd_t;

    // decoded work for the load/store unit
    typedef struct packed {
        logic                    valid;
        logic                    is_store;
        logic [4:0]              rd;
        logic [4:0]              rs1;
        logic [4:0]              rs2;
        logic [`FRISCV_XLEN-1:0] imm;
    } mem_cmd_t;

    // destination register write
    typedef struct packed {
        logic                    wr;
        logic [4:0]              addr;
        logic [`FRISCV_XLEN-1:0] val;
    } rd_write_t;

    // source register addresses
    typedef struct packed {
        logic [4:0] rs1;
        logic [4:0] rs2;
    } rs_read_t;

endpackage

`default_nettype wire

//--- logic/friscv_decoder.sv
// instruction decoder
// splits one word into an ALU or a memory command

`default_nettype none

`include "friscv_defines.svh"

module friscv_decoder
    import friscv_isa_pkg::*;
    import friscv_core_pkg::*;
(
    input  logic     instr_valid,
    input  instr_t   instr,
    output alu_cmd_t alu_cmd,
    output mem_cmd_t mem_cmd,
    output logic     illegal_instr
);

    logic [`FRISCV_XLEN-1:0] imm_i;
    logic [`FRISCV_XLEN-1:0] imm_s;
    logic [`FRISCV_XLEN-1:0] imm_u;
    logic                    alt;
    logic                    bad;
    alu_op_t                 op_f3;

    // sign extended immediates for each layout
    assign imm_i = {{(`FRISCV_XLEN-12){instr.i.imm[11]}}, instr.i.imm};
    assign imm_s = {{(`FRISCV_XLEN-12){instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
    assign imm_u = {instr.u.imm, 12'h000};

    assign alt = (instr.r.funct7 == F7_ALT);

    // funct3 to operation, funct7 picks SUB/SRA
    always_comb begin
        case (instr.r.funct3)
            F3_ADD_SUB: op_f3 = alt ? ALU_SUB : ALU_ADD;
            F3_SLL:     op_f3 = ALU_SLL;
            F3_SLT:     op_f3 = ALU_SLT;
            F3_SLTU:    op_f3 = ALU_SLTU;
            F3_XOR:     op_f3 = ALU_XOR;
            F3_SRL_SRA: op_f3 = alt ? ALU_SRA : ALU_SRL;
            F3_OR:      op_f3 = ALU_OR;
            default:    op_f3 = ALU_AND;
        endcase
    end

    always_comb begin
        alu_cmd = '0;
        mem_cmd = '0;
        bad = 1'b0;
        alu_cmd.op = op_f3;
        alu_cmd.rd = instr.r.rd;
        alu_cmd.rs1 = instr.r.rs1;
        alu_cmd.rs2 = instr.r.rs2;
        mem_cmd.rd = instr.i.rd;
        mem_cmd.rs1 = instr.i.rs1;
        mem_cmd.rs2 = instr.s.rs2;
        mem_cmd.imm = imm_i;

        case (instr.r.opcode)
            OPC_OP: begin
                alu_cmd.valid = 1'b1;
                // only ADD/SUB and SRL/SRA accept the alternate funct7
                bad = !(instr.r.funct7 == F7_BASE ||
                        (alt && (instr.r.funct3 == F3_ADD_SUB ||
                                 instr.r.funct3 == F3_SRL_SRA)));
            end
            OPC_OPIMM: begin
                alu_cmd.valid = 1'b1;
                alu_cmd.use_imm = 1'b1;
                alu_cmd.imm = imm_i;
                // there is no SUBI
                if (instr.r.funct3 == F3_ADD_SUB) begin
                    alu_cmd.op = ALU_ADD;
                end else if (instr.r.funct3 == F3_SLL) begin
                    bad = (instr.r.funct7 != F7_BASE);
                end else if (instr.r.funct3 == F3_SRL_SRA) begin
                    bad = !(instr.r.funct7 == F7_BASE || alt);
                end
            end
            OPC_LUI: begin
                alu_cmd.valid = 1'b1;
                alu_cmd.op = ALU_LUI;
                alu_cmd.use_imm = 1'b1;
                alu_cmd.imm = imm_u;
            end
            OPC_LOAD: begin
                mem_cmd.valid = 1'b1;
                bad = (instr.i.funct3 != F3_WORD);
            end
            OPC_STORE: begin
                mem_cmd.valid = 1'b1;
                mem_cmd.is_store = 1'b1;
                mem_cmd.imm = imm_s;
                bad = (instr.s.funct3 != F3_WORD);
            end
            default: begin
                bad = 1'b1;
            end
        endcase

        // no strobe or a bad word issues nothing
        if (!instr_valid || bad) begin
            alu_cmd.valid = 1'b0;
            mem_cmd.valid = 1'b0;
        end
    end

    assign illegal_instr = instr_valid && bad;

endmodule

`default_nettype wire

//--- logic/friscv_alu.sv
// integer ALU

`default_nettype none

`include "friscv_defines.svh"

module friscv_alu
    import friscv_isa_pkg::*;
    import friscv_core_pkg::*;
(
    input  alu_cmd_t                alu_cmd,
    output rs_read_t                rs_read,
    input  logic [`FRISCV_XLEN-1:0] rs1_val,
    input  logic [`FRISCV_XLEN-1:0] rs2_val,
    output rd_write_t               rd_write
);

    logic [`FRISCV_XLEN-1:0] opb;
    logic [`FRISCV_XLEN-1:0] result;
    logic [4:0]              shamt;

    assign rs_read.rs1 = alu_cmd.rs1;
    assign rs_read.rs2 = alu_cmd.rs2;

    // second operand, register or immediate
    assign opb = alu_cmd.use_imm ? alu_cmd.imm : rs2_val;
    assign shamt = opb[4:0];

    always_comb begin
        case (alu_cmd.op)
            ALU_ADD:  result = rs1_val + opb;
            ALU_SUB:  result = rs1_val - opb;
            ALU_SLL:  result = rs1_val << shamt;
            ALU_SLT:  result = {{(`FRISCV_XLEN-1){1'b0}}, $signed(rs1_val) < $signed(opb)};
            ALU_SLTU: result = {{(`FRISCV_XLEN-1){1'b0}}, rs1_val < opb};
            ALU_XOR:  result = rs1_val ^ opb;
            ALU_SRL:  result = rs1_val >> shamt;
            ALU_SRA:  result = $signed(rs1_val) >>> shamt;
            ALU_OR:   result = rs1_val | opb;
            ALU_AND:  result = rs1_val & opb;
            // immediate is already shifted by the decoder
            ALU_LUI:  result = alu_cmd.imm;
            default:  result = '0;
        endcase
    end

    assign rd_write.wr = alu_cmd.valid;
    assign rd_write.addr = alu_cmd.rd;
    assign rd_write.val = result;

endmodule

`default_nettype wire

//--- logic/friscv_memfy.sv
// load/store unit with local data memory

`default_nettype none

`include "friscv_defines.svh"

module friscv_memfy
    import friscv_core_pkg::*;
(
    input  logic                    aclk,
    input  logic                    aresetn,
    input  mem_cmd_t                mem_cmd,
    output rs_read_t                rs_read,
    input  logic [`FRISCV_XLEN-1:0] rs1_val,
    input  logic [`FRISCV_XLEN-1:0] rs2_val,
    output rd_write_t               rd_write
);

    localparam int DEPTH = `FRISCV_DMEM_DEPTH;
    localparam int IDX_W = $clog2(DEPTH);

    logic [`FRISCV_XLEN-1:0] dmem [DEPTH];
    logic [`FRISCV_XLEN-1:0] addr;
    logic [IDX_W-1:0]        idx;

    assign rs_read.rs1 = mem_cmd.rs1;
    assign rs_read.rs2 = mem_cmd.rs2;

    // byte address, word index wraps on the memory size
    assign addr = rs1_val + mem_cmd.imm;
    assign idx = addr[IDX_W+1:2];

    ////////////////////////////////////////////////////////////////////
    // store path
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            for (int w = 0; w < DEPTH; w++) begin
                dmem[w] <= '0;
            end
        end else if (mem_cmd.valid && mem_cmd.is_store) begin
            dmem[idx] <= rs2_val;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // load path, read straight from the array
    ////////////////////////////////////////////////////////////////////

    assign rd_write.wr = mem_cmd.valid && !mem_cmd.is_store;
    assign rd_write.addr = mem_cmd.rd;
    assign rd_write.val = dmem[idx];

endmodule

`default_nettype wire

//--- logic/friscv_registers.sv
// integer register file
// two write ports, five read ports

`default_nettype none

`include "friscv_defines.svh"

module friscv_registers
    import friscv_core_pkg::*;
(
    input  logic                    aclk,
    input  logic                    aresetn,
    input  logic                    srst,
    input  rs_read_t                alu_read,
    input  rs_read_t                mem_read,
    output logic [`FRISCV_XLEN-1:0] alu_rs1_val,
    output logic [`FRISCV_XLEN-1:0] alu_rs2_val,
    output logic [`FRISCV_XLEN-1:0] mem_rs1_val,
    output logic [`FRISCV_XLEN-1:0] mem_rs2_val,
    input  rd_write_t               alu_write,
    input  rd_write_t               mem_write,
    input  logic [4:0]              dbg_addr,
    output logic [`FRISCV_XLEN-1:0] dbg_val
);

    localparam int REGNUM = `FRISCV_REGNUM;

    logic [`FRISCV_XLEN-1:0] regs [REGNUM];

    // x0 is only ever written by reset, so it stays zero
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            for (int r = 0; r < REGNUM; r++) begin
                regs[r] <= '0;
            end
        end else begin
            for (int r = 1; r < REGNUM; r++) begin
                if (srst) begin
                    regs[r] <= '0;
                end else if (mem_write.wr && mem_write.addr == r) begin
                    regs[r] <= mem_write.val;
                end else if (alu_write.wr && alu_write.addr == r) begin
                    regs[r] <= alu_write.val;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////
    // read ports, addresses past the last register return zero
    ////////////////////////////////////////////////////////////////////

    assign alu_rs1_val = (alu_read.rs1 < REGNUM) ? regs[alu_read.rs1] : '0;
    assign alu_rs2_val = (alu_read.rs2 < REGNUM) ? regs[alu_read.rs2] : '0;
    assign mem_rs1_val = (mem_read.rs1 < REGNUM) ? regs[mem_read.rs1] : '0;
    assign mem_rs2_val = (mem_read.rs2 < REGNUM) ? regs[mem_read.rs2] : '0;
    assign dbg_val = (dbg_addr < REGNUM) ? regs[dbg_addr] : '0;

endmodule

`default_nettype wire

//--- logic/friscv_exec_top.sv
// rv32i execution subsystem top

`default_nettype none

`include "friscv_defines.svh"

module friscv_exec_top
    import friscv_isa_pkg::*;
    import friscv_core_pkg::*;
(
    input  logic                    aclk,
    input  logic                    aresetn,
    input  logic                    srst,
    input  logic                    instr_valid,
    input  instr_t                  instr,
    input  logic [4:0]              dbg_addr,
    output logic [`FRISCV_XLEN-1:0] dbg_val,
    output logic                    retired,
    output logic                    illegal
);

    alu_cmd_t                alu_cmd;
    mem_cmd_t                mem_cmd;
    logic                    illegal_instr;
    rs_read_t                alu_read;
    rs_read_t                mem_read;
    rd_write_t               alu_write;
    rd_write_t               mem_write;
    logic [`FRISCV_XLEN-1:0] alu_rs1_val;
    logic [`FRISCV_XLEN-1:0] alu_rs2_val;
    logic [`FRISCV_XLEN-1:0] mem_rs1_val;
    logic [`FRISCV_XLEN-1:0] mem_rs2_val;

    friscv_decoder u_decoder (
        .instr_valid   (instr_valid),
        .instr         (instr),
        .alu_cmd       (alu_cmd),
        .mem_cmd       (mem_cmd),
        .illegal_instr (illegal_instr)
    );

    friscv_alu u_alu (
        .alu_cmd  (alu_cmd),
        .rs_read  (alu_read),
        .rs1_val  (alu_rs1_val),
        .rs2_val  (alu_rs2_val),
        .rd_write (alu_write)
    );

    friscv_memfy u_memfy (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .mem_cmd  (mem_cmd),
        .rs_read  (mem_read),
        .rs1_val  (mem_rs1_val),
        .rs2_val  (mem_rs2_val),
        .rd_write (mem_write)
    );

    friscv_registers u_registers (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .srst        (srst),
        .alu_read    (alu_read),
        .mem_read    (mem_read),
        .alu_rs1_val (alu_rs1_val),
        .alu_rs2_val (alu_rs2_val),
        .mem_rs1_val (mem_rs1_val),
        .mem_rs2_val (mem_rs2_val),
        .alu_write   (alu_write),
        .mem_write   (mem_write),
        .dbg_addr    (dbg_addr),
        .dbg_val     (dbg_val)
    );

    // status pulses, one cycle after the write edge
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            retired <= 1'b0;
            illegal <= 1'b0;
        end else begin
            retired <= alu_cmd.valid || mem_cmd.valid;
            illegal <= illegal_instr;
        end
    end

endmodule

`default_nettype wire

//--- verif/friscv_tb_model.svh
// reference model and instruction generator

`ifndef FRISCV_TB_MODEL_SVH
`define FRISCV_TB_MODEL_SVH

logic [31:0]             lcg_state;
logic [`FRISCV_XLEN-1:0] model_regs [`FRISCV_REGNUM];
logic [`FRISCV_XLEN-1:0] model_mem [`FRISCV_DMEM_DEPTH];

// two steps per call, upper halves only
function automatic logic [31:0] lcg_next();
    logic [15:0] hi;
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    hi = lcg_state[31:16];
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return {hi, lcg_state[31:16]};
endfunction

////////////////////////////////////////////////////////////////////
// instruction generators
////////////////////////////////////////////////////////////////////

function automatic logic [31:0] gen_op();
    logic [31:0] r;
    logic [2:0]  f3;
    logic [6:0]  f7;
    r = lcg_next();
    f3 = r[2:0];
    f7 = (r[3] && (f3 == F3_ADD_SUB || f3 == F3_SRL_SRA)) ? F7_ALT : F7_BASE;
    return {f7, r[8:4], r[13:9], f3, r[18:14], OPC_OP};
endfunction

// mostly OP-IMM, about one in eight is LUI
function automatic logic [31:0] gen_imm();
    logic [31:0] r;
    logic [31:0] s;
    logic [2:0]  f3;
    logic [11:0] imm;
    r = lcg_next();
    s = lcg_next();
    f3 = r[2:0];
    imm = s[11:0];
    if (r[31:29] == 3'd0) begin
        return {s[19:0], r[18:14], OPC_LUI};
    end
    if (f3 == F3_SLL) begin
        imm[11:5] = F7_BASE;
    end else if (f3 == F3_SRL_SRA) begin
        imm[11:5] = s[12] ? F7_ALT : F7_BASE;
    end
    return {imm, r[13:9], f3, r[18:14], OPC_OPIMM};
endfunction

function automatic logic [31:0] gen_mem(input logic store);
    logic [31:0] r;
    logic [11:0] imm;
    r = lcg_next();
    imm = r[30:19];
    if (store) begin
        return {imm[11:5], r[8:4], r[13:9], F3_WORD, imm[4:0], OPC_STORE};
    end
    return {imm, r[13:9], F3_WORD, r[18:14], OPC_LOAD};
endfunction

// any opcode outside the supported five
function automatic logic [31:0] gen_bad();
    logic [31:0] r;
    logic [6:0]  opc;
    r = lcg_next();
    opc = r[6:0];
    while (opc inside {OPC_OP, OPC_OPIMM, OPC_LUI, OPC_LOAD, OPC_STORE}) begin
        opc = opc + 7'd1;
    end
    return {r[31:7], opc};
endfunction

////////////////////////////////////////////////////////////////////
// architectural state
////////////////////////////////////////////////////////////////////

function automatic logic [31:0] model_read(input logic [4:0] r);
    return (r < `FRISCV_REGNUM) ? model_regs[r] : '0;
endfunction

task automatic model_clear_regs();
    for (int r = 0; r < `FRISCV_REGNUM; r++) begin
        model_regs[r] = '0;
    end
endtask

task automatic model_reset();
    model_clear_regs();
    for (int m = 0; m < `FRISCV_DMEM_DEPTH; m++) begin
        model_mem[m] = '0;
    end
endtask

// legal tells if the word retires, chk if rd gets a value worth checking
task automatic model_exec(input logic [31:0] w, output logic legal, output logic chk,
                          output logic [4:0] rd);
    logic [6:0]  opc;
    logic [6:0]  f7;
    logic [2:0]  f3;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] immi;
    logic [31:0] imms;
    logic [31:0] res;
    logic [31:0] addr;
    int          idx;
    opc = w[6:0];
    f3 = w[14:12];
    f7 = w[31:25];
    rd = w[11:7];
    immi = {{20{w[31]}}, w[31:20]};
    imms = {{20{w[31]}}, w[31:25], w[11:7]};
    a = model_read(w[19:15]);
    b = (opc == OPC_OP) ? model_read(w[24:20]) : immi;
    legal = 1'b1;
    chk = 1'b1;
    res = '0;
    case (opc)
        OPC_OP: begin
            legal = (f7 == F7_BASE) ||
                    (f7 == F7_ALT && (f3 == F3_ADD_SUB || f3 == F3_SRL_SRA));
        end
        OPC_OPIMM: begin
            if (f3 == F3_SLL) begin
                legal = (f7 == F7_BASE);
            end else if (f3 == F3_SRL_SRA) begin
                legal = (f7 == F7_BASE || f7 == F7_ALT);
            end
        end
        OPC_LUI: begin
            legal = 1'b1;
        end
        OPC_LOAD: begin
            legal = (f3 == F3_WORD);
        end
        OPC_STORE: begin
            legal = (f3 == F3_WORD);
            chk = 1'b0;
        end
        default: begin
            legal = 1'b0;
        end
    endcase
    if (!legal) begin
        chk = 1'b0;
        return;
    end
    if (opc == OPC_LUI) begin
        res = {w[31:12], 12'h000};
    end else if (opc == OPC_LOAD || opc == OPC_STORE) begin
        addr = a + ((opc == OPC_STORE) ? imms : immi);
        idx = addr[31:2] % `FRISCV_DMEM_DEPTH;
        if (opc == OPC_STORE) begin
            model_mem[idx] = model_read(w[24:20]);
        end else begin
            res = model_mem[idx];
        end
    end else begin
        case (f3)
            3'd0: res = (opc == OPC_OP && f7 == F7_ALT) ? a - b : a + b;
            3'd1: res = a << b[4:0];
            3'd2: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: res = (a < b) ? 32'd1 : 32'd0;
            3'd4: res = a ^ b;
            3'd5: begin
                if (f7 == F7_ALT) begin
                    res = $signed(a) >>> b[4:0];
                end else begin
                    res = a >> b[4:0];
                end
            end
            3'd6: res = a | b;
            default: res = a & b;
        endcase
    end
    if (chk && rd != 5'd0 && rd < `FRISCV_REGNUM) begin
        model_regs[rd] = res;
    end
endtask

`endif

//--- verif/friscv_tb.sv
// testbench for the rv32i execution subsystem

`default_nettype none

`include "friscv_defines.svh"

module friscv_tb
    import friscv_isa_pkg::*;
();

    localparam int N_INSTR = 400;
    localparam int RESET_CYCLES = 5;
    // five tests of N_INSTR, with room for the sweeps, reset and srst traffic
    localparam int TIMEOUT_CYCLES = 3 * 5 * N_INSTR;

    logic                    aclk;
    logic                    aresetn;
    logic                    srst;
    logic                    instr_valid;
    logic [31:0]             instr_word;
    logic [4:0]              dbg_addr;
    logic [`FRISCV_XLEN-1:0] dbg_val;
    logic                    retired;
    logic                    illegal;

    `include "friscv_tb_model.svh"

    string       test_name;
    int          test_checks;
    int          test_errs;
    int          total_checks;
    int          total_errs;
    int          tests_run;
    int          tests_failed;
    int          cycles;
    // outcome expected one edge after the last issued word
    logic        pend_valid;
    logic        pend_legal;
    logic        pend_chk;
    logic [4:0]  pend_rd;

    friscv_exec_top UUT (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .srst        (srst),
        .instr_valid (instr_valid),
        .instr       (instr_word),
        .dbg_addr    (dbg_addr),
        .dbg_val     (dbg_val),
        .retired     (retired),
        .illegal     (illegal)
    );

    initial begin
        aclk = 1'b0;
        forever #5 aclk = ~aclk;
    end

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge aclk);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Test failures found");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // checks and stimulus
    //////////////////////////////////////////////////////////////////////

    task automatic check_eq(input string what, input logic [31:0] exp, input logic [31:0] act);
        test_checks++;
        assert (act === exp) else begin
            $display("ERR %s (%s): expected %h, actual %h", test_name, what, exp, act);
            test_errs++;
        end
    endtask

    task automatic check_prev();
        check_eq("retired", pend_valid && pend_legal, retired);
        check_eq("illegal", pend_valid && !pend_legal, illegal);
        if (pend_chk) begin
            check_eq($sformatf("x%0d", pend_rd), model_read(pend_rd), dbg_val);
        end
    endtask

    // check the previous word, then present the next one
    task automatic issue(input logic valid, input logic [31:0] w);
        logic       legal;
        logic       chk;
        logic [4:0] rd;
        @(posedge aclk);
        #1;
        check_prev();
        legal = 1'b0;
        chk = 1'b0;
        rd = '0;
        if (valid) begin
            model_exec(w, legal, chk, rd);
        end
        instr_valid = valid;
        instr_word = w;
        dbg_addr = rd;
        pend_valid = valid;
        pend_legal = legal;
        pend_chk = chk;
        pend_rd = rd;
    endtask

    task automatic sweep_regs();
        for (int r = 0; r < 32; r++) begin
            @(posedge aclk);
            #1;
            dbg_addr = r[4:0];
            #1;
            check_eq("sweep", model_read(r[4:0]), dbg_val);
        end
    endtask

    task automatic pulse_srst();
        srst = 1'b1;
        model_clear_regs();
        @(posedge aclk);
        #1;
        srst = 1'b0;
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_checks = 0;
        test_errs = 0;
    endtask

    task automatic end_test();
        issue(1'b0, '0);
        $display("test %s: %0d checks, %0d errors", test_name, test_checks, test_errs);
        tests_run++;
        total_checks += test_checks;
        total_errs += test_errs;
        if (test_errs != 0) begin
            tests_failed++;
        end
    endtask

    initial begin
        logic [31:0] w;
        logic [31:0] sel;
        logic [4:0]  rd;
        aresetn = 1'b0;
        srst = 1'b0;
        instr_valid = 1'b0;
        instr_word = '0;
        dbg_addr = '0;
        lcg_state = 32'he717eaad;
        pend_valid = 1'b0;
        pend_legal = 1'b0;
        pend_chk = 1'b0;
        pend_rd = '0;
        total_checks = 0;
        total_errs = 0;
        tests_run = 0;
        tests_failed = 0;
        model_reset();
        repeat (RESET_CYCLES) @(posedge aclk);
        #1;
        aresetn = 1'b1;

        start_test("reg_reg");
        repeat (N_INSTR) issue(1'b1, gen_op());
        end_test();

        start_test("imm_lui");
        repeat (N_INSTR) issue(1'b1, gen_imm());
        end_test();

        start_test("load_store");
        repeat (N_INSTR) begin
            sel = lcg_next();
            issue(1'b1, gen_mem(sel[31]));
        end
        end_test();

        // every kind of register write, aimed at x0
        start_test("x0_write");
        repeat (N_INSTR) begin
            sel = lcg_next();
            case (sel[31:30])
                2'd0: w = gen_op();
                2'd1: w = gen_imm();
                default: w = gen_mem(1'b0);
            endcase
            w[11:7] = 5'd0;
            issue(1'b1, w);
        end
        end_test();

        start_test("illegal");
        repeat (N_INSTR) issue(1'b1, gen_bad());
        issue(1'b0, '0);
        sweep_regs();
        end_test();

        // stores from x0 put data at known words before the clear
        start_test("srst");
        repeat (100) issue(1'b1, gen_op());
        repeat (32) begin
            w = lcg_next();
            issue(1'b1, {7'd0, w[8:4], 5'd0, F3_WORD, w[21:17], OPC_STORE});
        end
        issue(1'b0, '0);
        pulse_srst();
        sweep_regs();
        for (int k = 0; k < `FRISCV_DMEM_DEPTH; k++) begin
            w = lcg_next();
            rd = 5'd1 + (w[31:27] % 5'd31);
            issue(1'b1, {4'd0, k[5:0], 2'b00, 5'd0, F3_WORD, rd, OPC_LOAD});
        end
        end_test();

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, total_checks, total_errs);
        if (total_errs == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
+incdir+logic
+incdir+verif
logic/friscv_isa_pkg.sv
logic/friscv_core_pkg.sv
logic/friscv_decoder.sv
logic/friscv_alu.sv
logic/friscv_memfy.sv
logic/friscv_registers.sv
logic/friscv_exec_top.sv
verif/friscv_tb.sv
